// ==== tb.f ====
common/scrub_pkg.sv
hw/rst_sync.sv
hw/scrub_ctl.sv
scrubber/ddr_scrubber.sv
hw/scrub_status.sv
hw/scrub_top.sv
test/tb_ddr_slave.sv
test/tb_scrub_top.sv

// ==== test/tb_scrub_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_scrub_top;

  import scrub_pkg::*;

  logic                clk;
  logic                rst_main_n;
  logic [31:0]         ctl0;
  logic [num_ch-1:0]   ddr_is_ready;
  logic                flr_assert;
  logic                flr_done;
  logic [31:0]         id0;
  logic [31:0]         id1;
  logic [num_ch-1:0]   scrb_done_vec;

  logic                awvalid [num_ch];
  logic                awready [num_ch];
  logic [addr_w-1:0]   awaddr  [num_ch];
  logic [id_w-1:0]     awid    [num_ch];
  logic [7:0]          awlen   [num_ch];
  logic [2:0]          awsize  [num_ch];
  logic                wvalid  [num_ch];
  logic                wready  [num_ch];
  logic [data_w-1:0]   wdata   [num_ch];
  logic [strb_w-1:0]   wstrb   [num_ch];
  logic                wlast   [num_ch];
  logic                bvalid  [num_ch];
  logic [1:0]          bresp   [num_ch];
  logic                bready  [num_ch];

  logic                busy         [num_ch];
  logic                ev_stb       [num_ch];
  logic [addr_w-1:0]   ev_addr      [num_ch];
  logic [7:0]          ev_len       [num_ch];
  logic [2:0]          ev_size      [num_ch];
  logic [7:0]          ev_beats     [num_ch];
  logic [7:0]          ev_wlast_pos [num_ch];
  logic [7:0]          ev_wlast_cnt [num_ch];
  logic                ev_data_ok   [num_ch];
  logic                ev_strb_ok   [num_ch];

  // Burst addresses seen per channel, checked against the expected sequence
  logic [addr_w-1:0]   got_addr [num_ch][$];
  int                  errors;
  int                  timeouts;

  scrub_top i_scrub_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // Slaves and per-burst checks
  // --------------------------------------------------
  for (genvar ch = 0; ch < num_ch; ch++)
  begin : g_slv
    tb_ddr_slave i_slave (
      .clk (clk), .rst_n (rst_main_n),
      .awvalid (awvalid[ch]), .awready (awready[ch]), .awaddr (awaddr[ch]),
      .awlen (awlen[ch]), .awsize (awsize[ch]),
      .wvalid (wvalid[ch]), .wready (wready[ch]), .wdata (wdata[ch]),
      .wstrb (wstrb[ch]), .wlast (wlast[ch]),
      .bvalid (bvalid[ch]), .bresp (bresp[ch]), .bready (bready[ch]),
      .busy (busy[ch]), .ev_stb (ev_stb[ch]), .ev_addr (ev_addr[ch]),
      .ev_len (ev_len[ch]), .ev_size (ev_size[ch]), .ev_beats (ev_beats[ch]),
      .ev_wlast_pos (ev_wlast_pos[ch]), .ev_wlast_cnt (ev_wlast_cnt[ch]),
      .ev_data_ok (ev_data_ok[ch]), .ev_strb_ok (ev_strb_ok[ch])
    );

    always @(posedge clk)
    begin
      if (awvalid[ch] && awready[ch])
        check_val($sformatf("ch%0d awid", ch), 64'd0, awid[ch]);
      if (ev_stb[ch])
      begin
        got_addr[ch].push_back(ev_addr[ch]);
        check_val($sformatf("ch%0d awlen", ch), 64'd15, ev_len[ch]);
        check_val($sformatf("ch%0d awsize", ch), 64'd6, ev_size[ch]);
        check_val($sformatf("ch%0d beats", ch), 64'd16, ev_beats[ch]);
        check_val($sformatf("ch%0d wlast_pos", ch), 64'd15, ev_wlast_pos[ch]);
        check_val($sformatf("ch%0d wlast_cnt", ch), 64'd1, ev_wlast_cnt[ch]);
        check_val($sformatf("ch%0d zero_data", ch), 64'd1, ev_data_ok[ch]);
        check_val($sformatf("ch%0d full_strb", ch), 64'd1, ev_strb_ok[ch]);
      end
    end
  end

  task automatic wait_bursts(input int ch, input int n, input string what);
    int i;
    for (i = 0; i < 20000; i++)
    begin
      @(negedge clk);
      if (got_addr[ch].size() >= n)
        return;
    end
    timeouts++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic wait_done_vec(input logic [num_ch-1:0] val, input string what);
    int i;
    for (i = 0; i < 20000; i++)
    begin
      @(negedge clk);
      if (scrb_done_vec === val)
        return;
    end
    timeouts++;
    $display("Timeout while waiting for %s", what);
  endtask

  // Channel counts as idle after a few quiet cycles in a row
  task automatic wait_idle(input int ch);
    int i;
    int quiet;
    quiet = 0;
    for (i = 0; i < 5000; i++)
    begin
      @(negedge clk);
      quiet = (!awvalid[ch] && !wvalid[ch] && !busy[ch]) ? quiet + 1 : 0;
      if (quiet >= 4)
        return;
    end
    timeouts++;
    $display("Timeout while waiting for channel %0d to go idle", ch);
  endtask

  task automatic drive_ctl(input logic [31:0] val);
    @(posedge clk);
    ctl0 <= val;
  endtask

  initial
  begin
    int n;
    int k;
    int sel;
    int exp_ch;
    int pulses;
    logic [num_ch-1:0] mask;
    logic [addr_w-1:0] exp_addr;
    errors     = 0;
    timeouts   = 0;
    void'($urandom(23));
    rst_main_n <= 1'b0;
    ctl0       <= '0;
    ddr_is_ready <= '0;
    flr_assert <= 1'b0;
    repeat (16) @(posedge clk);
    rst_main_n <= 1'b1;
    repeat (10) @(posedge clk);

    // FLR acknowledge timing
    flr_assert <= 1'b1;
    pulses = 0;
    for (int c = 1; c <= 8; c++)
    begin
      @(posedge clk);
      @(negedge clk);
      if (flr_done)
      begin
        pulses++;
        if (pulses == 1)
          check_val("flr_latency", 64'd2, c);
      end
    end
    check_val("flr_pulses", 64'd1, pulses);
    @(posedge clk);
    flr_assert <= 1'b0;

    // Per-bit enables and ready gating
    @(posedge clk);
    ctl0 <= 32'h0000_0007;
    ddr_is_ready <= 4'b0011;
    wait_bursts(0, 2, "channel 0 bursts");
    check_val("ch2_not_ready", 64'd0, got_addr[2].size());
    check_val("ch3_disabled", 64'd0, got_addr[3].size());
    @(posedge clk);
    ddr_is_ready <= 4'b1111;
    wait_bursts(2, 1, "channel 2 after ready");
    check_val("ch3_still_idle", 64'd0, got_addr[3].size());
    check_val("ch3_done_low", 64'd0, scrb_done_vec[3]);

    // Full scrub on all channels
    drive_ctl(32'h0000_000F);
    wait_done_vec(4'hF, "all channels done");
    repeat (4) @(posedge clk);
    for (int ch = 0; ch < num_ch; ch++)
    begin
      check_val($sformatf("ch%0d burst_count", ch), 64'd8, got_addr[ch].size());
      for (int i = 0; i < got_addr[ch].size(); i++)
        check_val($sformatf("ch%0d addr%0d", ch, i), 64'(i * 1024), got_addr[ch][i]);
    end

    // ID outputs, fixed and debug views
    @(negedge clk);
    check_val("id0_fixed", cl_id0, id0);
    check_val("id1_fixed", cl_id1, id1);
    // Disabled channels rewind to 0, done ones keep their last burst address
    for (int r = 0; r < 2; r++)
    begin
      mask = (r == 0) ? 4'b0101 : 4'b0011;
      drive_ctl(32'(mask));
      wait_done_vec(mask, "done flags to follow the enables");
      repeat (4) @(posedge clk);
      for (sel = 0; sel < 8; sel++)
      begin
        exp_ch = (sel < num_ch) ? sel : 0;
        exp_addr = mask[exp_ch] ? got_addr[exp_ch][$] : '0;
        drive_ctl(32'h8000_0000 | 32'(mask) | (32'(sel) << 28));
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_val($sformatf("id0_sel%0d_round%0d", sel, r), exp_addr[31:0], id0);
        check_val($sformatf("id1_sel%0d_round%0d", sel, r), exp_addr[63:32], id1);
      end
    end
    drive_ctl(32'(mask));
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_val("id0_fixed_after_dbg", cl_id0, id0);
    check_val("id1_fixed_after_dbg", cl_id1, id1);

    // Disable mid-scrub and restart
    drive_ctl(32'h0);
    wait_done_vec(4'h0, "done flags to clear");
    for (int ch = 0; ch < num_ch; ch++)
      got_addr[ch].delete();
    drive_ctl(32'h0000_0002);
    wait_bursts(1, 3, "channel 1 partial scrub");
    drive_ctl(32'h0);
    wait_idle(1);
    n = got_addr[1].size();
    if (n < 3 || n > 4)
    begin
      errors++;
      $display("Channel 1 issued %0d bursts around the disable, outside 3 to 4", n);
    end
    for (int i = 0; i < n; i++)
      check_val($sformatf("ch1 partial addr%0d", i), 64'(i * 1024), got_addr[1][i]);
    check_val("ch1_done_cleared", 64'd0, scrb_done_vec[1]);
    k = n;
    drive_ctl(32'h0000_0002);
    wait_bursts(1, k + 1, "channel 1 restart");
    if (got_addr[1].size() > k)
      check_val("ch1_restart_addr", 64'd0, got_addr[1][k]);
    drive_ctl(32'h0);
    wait_idle(1);

    $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tb_ddr_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ddr_slave (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           awvalid,
  output logic                          awready,
  input  wire  [scrub_pkg::addr_w-1:0]  awaddr,
  input  wire  [7:0]                    awlen,
  input  wire  [2:0]                    awsize,
  input  wire                           wvalid,
  output logic                          wready,
  input  wire  [scrub_pkg::data_w-1:0]  wdata,
  input  wire  [scrub_pkg::strb_w-1:0]  wstrb,
  input  wire                           wlast,
  output logic                          bvalid,
  output logic [1:0]                    bresp,
  input  wire                           bready,
  output logic                          busy,
  output logic                          ev_stb,
  output logic [scrub_pkg::addr_w-1:0]  ev_addr,
  output logic [7:0]                    ev_len,
  output logic [2:0]                    ev_size,
  output logic [7:0]                    ev_beats,
  output logic [7:0]                    ev_wlast_pos,
  output logic [7:0]                    ev_wlast_cnt,
  output logic                          ev_data_ok,
  output logic                          ev_strb_ok
);

  logic [1:0] b_wait;

  initial
  begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = 2'b00;
    busy    = 1'b0;
    ev_stb  = 1'b0;
  end

  // Random stalls on every ready, burst recording on each handshake
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      busy    <= 1'b0;
      ev_stb  <= 1'b0;
    end
    else
    begin
      awready <= ($urandom % 4) != 0;
      wready  <= ($urandom % 3) != 0;
      ev_stb  <= 1'b0;
      if (awvalid && awready)
      begin
        busy         <= 1'b1;
        ev_addr      <= awaddr;
        ev_len       <= awlen;
        ev_size      <= awsize;
        ev_beats     <= 8'd0;
        ev_wlast_pos <= 8'hFF;
        ev_wlast_cnt <= 8'd0;
        ev_data_ok   <= 1'b1;
        ev_strb_ok   <= 1'b1;
      end
      if (wvalid && wready)
      begin
        ev_beats <= ev_beats + 8'd1;
        if (wdata != '0)
          ev_data_ok <= 1'b0;
        if (wstrb != '1)
          ev_strb_ok <= 1'b0;
        if (wlast)
        begin
          ev_wlast_cnt <= ev_wlast_cnt + 8'd1;
          if (ev_wlast_cnt == 8'd0)
            ev_wlast_pos <= ev_beats;
          b_wait <= 2'($urandom % 4);
        end
      end
      // Response after the last beat and a random delay
      if (bvalid && bready)
      begin
        bvalid <= 1'b0;
        busy   <= 1'b0;
        ev_stb <= 1'b1;
      end
      else if (busy && !bvalid && ev_wlast_cnt != 8'd0)
      begin
        if (b_wait == 2'd0)
          bvalid <= 1'b1;
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/scrub_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module scrub_top (
  input  wire                           clk,
  input  wire                           rst_main_n,
  input  wire  [31:0]                   ctl0,
  input  wire  [scrub_pkg::num_ch-1:0]  ddr_is_ready,
  input  wire                           flr_assert,
  output logic                          flr_done,
  output logic [31:0]                   id0,
  output logic [31:0]                   id1,
  output logic [scrub_pkg::num_ch-1:0]  scrb_done_vec,

  // Per-channel AXI write channels
  output logic                          awvalid [scrub_pkg::num_ch],
  input  wire                           awready [scrub_pkg::num_ch],
  output logic [scrub_pkg::addr_w-1:0]  awaddr  [scrub_pkg::num_ch],
  output logic [scrub_pkg::id_w-1:0]    awid    [scrub_pkg::num_ch],
  output logic [7:0]                    awlen   [scrub_pkg::num_ch],
  output logic [2:0]                    awsize  [scrub_pkg::num_ch],
  output logic                          wvalid  [scrub_pkg::num_ch],
  input  wire                           wready  [scrub_pkg::num_ch],
  output logic [scrub_pkg::data_w-1:0]  wdata   [scrub_pkg::num_ch],
  output logic [scrub_pkg::strb_w-1:0]  wstrb   [scrub_pkg::num_ch],
  output logic                          wlast   [scrub_pkg::num_ch],
  input  wire                           bvalid  [scrub_pkg::num_ch],
  input  wire  [1:0]                    bresp   [scrub_pkg::num_ch],
  output logic                          bready  [scrub_pkg::num_ch]
);

  import scrub_pkg::*;

  logic                     sync_rst_n;
  logic [num_ch-1:0]        scrb_en;
  logic [num_ch-1:0]        ddr_ready_q;
  logic                     dbg_en;
  logic [ctl_dbg_sel_w-1:0] dbg_sel;
  scrb_addr_u               scrb_addr [num_ch];
  logic                     scrb_done [num_ch];

  rst_sync i_rst_sync (
    .clk        (clk),
    .rst_main_n (rst_main_n),
    .sync_rst_n (sync_rst_n)
  );

  scrub_ctl i_scrub_ctl (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .ctl0         (ctl0),
    .ddr_is_ready (ddr_is_ready),
    .flr_assert   (flr_assert),
    .scrb_en      (scrb_en),
    .ddr_ready_q  (ddr_ready_q),
    .dbg_en       (dbg_en),
    .dbg_sel      (dbg_sel),
    .flr_done     (flr_done)
  );

  // --------------------------------------------------
  // One scrubber per DDR channel
  // --------------------------------------------------
  for (genvar ch = 0; ch < num_ch; ch++)
  begin : g_ch
    ddr_scrubber i_ddr_scrubber (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en[ch]),
      .ddr_ready  (ddr_ready_q[ch]),
      .awvalid    (awvalid[ch]),
      .awready    (awready[ch]),
      .awaddr     (awaddr[ch]),
      .awid       (awid[ch]),
      .awlen      (awlen[ch]),
      .awsize     (awsize[ch]),
      .wvalid     (wvalid[ch]),
      .wready     (wready[ch]),
      .wdata      (wdata[ch]),
      .wstrb      (wstrb[ch]),
      .wlast      (wlast[ch]),
      .bvalid     (bvalid[ch]),
      .bresp      (bresp[ch]),
      .bready     (bready[ch]),
      .scrb_addr  (scrb_addr[ch]),
      .scrb_done  (scrb_done[ch])
    );
  end

  scrub_status i_scrub_status (
    .clk           (clk),
    .sync_rst_n    (sync_rst_n),
    .dbg_en        (dbg_en),
    .dbg_sel       (dbg_sel),
    .scrb_addr     (scrb_addr),
    .scrb_done     (scrb_done),
    .id0           (id0),
    .id1           (id1),
    .scrb_done_vec (scrb_done_vec)
  );

endmodule

`default_nettype wire

// ==== hw/scrub_status.sv ====
`timescale 1ns/10ps
`default_nettype none

module scrub_status (
  input  wire                                  clk,
  input  wire                                  sync_rst_n,
  input  wire                                  dbg_en,
  input  wire  [scrub_pkg::ctl_dbg_sel_w-1:0]  dbg_sel,
  input  wire  scrub_pkg::scrb_addr_u          scrb_addr [scrub_pkg::num_ch],
  input  wire                                  scrb_done [scrub_pkg::num_ch],
  output logic [31:0]                          id0,
  output logic [31:0]                          id1,
  output logic [scrub_pkg::num_ch-1:0]         scrb_done_vec
);

  import scrub_pkg::*;

  logic [ch_idx_w-1:0] sel_ch;
  scrb_addr_u          sel_addr;

  // Out of range selects fall back to channel 0
  always_comb
  begin
    if (dbg_sel < num_ch)
      sel_ch = dbg_sel[ch_idx_w-1:0];
    else
      sel_ch = '0;
  end

  assign sel_addr = scrb_addr[sel_ch];

  // --------------------------------------------------
  // ID outputs, fixed words or the debug address view
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      id0 <= cl_id0;
      id1 <= cl_id1;
    end
    else if (dbg_en)
    begin
      id0 <= sel_addr.half.lo;
      id1 <= sel_addr.half.hi;
    end
    else
    begin
      id0 <= cl_id0;
      id1 <= cl_id1;
    end
  end

  // Done flags gathered into one vector
  always_comb
  begin
    for (int i = 0; i < num_ch; i++)
    begin
      scrb_done_vec[i] = scrb_done[i];
    end
  end

endmodule

`default_nettype wire

// ==== scrubber/ddr_scrubber.sv ====
`timescale 1ns/10ps
`default_nettype none

module ddr_scrubber (
  input  wire                           clk,
  input  wire                           sync_rst_n,
  input  wire                           scrb_en,
  input  wire                           ddr_ready,
  output logic                          awvalid,
  input  wire                           awready,
  output logic [scrub_pkg::addr_w-1:0]  awaddr,
  output logic [scrub_pkg::id_w-1:0]    awid,
  output logic [7:0]                    awlen,
  output logic [2:0]                    awsize,
  output logic                          wvalid,
  input  wire                           wready,
  output logic [scrub_pkg::data_w-1:0]  wdata,
  output logic [scrub_pkg::strb_w-1:0]  wstrb,
  output logic                          wlast,
  input  wire                           bvalid,
  input  wire  [1:0]                    bresp,
  output logic                          bready,
  output scrub_pkg::scrb_addr_u         scrb_addr,
  output logic                          scrb_done
);

  import scrub_pkg::*;

  logic [1:0]        state;
  logic [7:0]        beat_cnt;
  logic [addr_w-1:0] next_addr;
  logic              last_burst;

  assign next_addr  = scrb_addr.full + burst_bytes;
  assign last_burst = next_addr > scrb_max_addr;

  // --------------------------------------------------
  // Fixed burst attributes, zero data with full strobes
  // --------------------------------------------------
  assign awaddr = scrb_addr.full;
  assign awid   = '0;
  assign awlen  = burst_len;
  assign awsize = burst_size;
  assign wdata  = '0;
  assign wstrb  = '1;

  // Responses are taken as soon as they show up
  assign bready = 1'b1;

  // --------------------------------------------------
  // Burst FSM, one burst in flight
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      state     <= st_idle;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      wlast     <= 1'b0;
      beat_cnt  <= '0;
      scrb_addr <= '0;
      scrb_done <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          // Disable rewinds the engine so a later enable starts over
          if (!scrb_en)
          begin
            scrb_addr <= '0;
            scrb_done <= 1'b0;
          end
          else if (ddr_ready && !scrb_done)
          begin
            awvalid <= 1'b1;
            state   <= st_addr;
          end
        end

        st_addr:
        begin
          if (awready)
          begin
            awvalid  <= 1'b0;
            wvalid   <= 1'b1;
            wlast    <= (burst_len == 8'd0);
            beat_cnt <= '0;
            state    <= st_data;
          end
        end

        st_data:
        begin
          if (wready)
          begin
            if (wlast)
            begin
              wvalid <= 1'b0;
              wlast  <= 1'b0;
              state  <= st_resp;
            end
            else
            begin
              beat_cnt <= beat_cnt + 8'd1;
              wlast    <= (beat_cnt + 8'd1) == burst_len;
            end
          end
        end

        default:
        begin
          // Response status does not change the scrub
          if (bvalid)
          begin
            if (last_burst)
              scrb_done <= 1'b1;
            else
              scrb_addr.full <= next_addr;
            state <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/scrub_ctl.sv ====
`timescale 1ns/10ps
`default_nettype none

module scrub_ctl (
  input  wire                                  clk,
  input  wire                                  sync_rst_n,
  input  wire  [31:0]                          ctl0,
  input  wire  [scrub_pkg::num_ch-1:0]         ddr_is_ready,
  input  wire                                  flr_assert,
  output logic [scrub_pkg::num_ch-1:0]         scrb_en,
  output logic [scrub_pkg::num_ch-1:0]         ddr_ready_q,
  output logic                                 dbg_en,
  output logic [scrub_pkg::ctl_dbg_sel_w-1:0]  dbg_sel,
  output logic                                 flr_done
);

  import scrub_pkg::*;

  logic [31:0] ctl0_q;
  logic        flr_assert_q;
  logic        flr_assert_qq;

  // --------------------------------------------------
  // Input registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      ctl0_q       <= '0;
      ddr_ready_q  <= '0;
      flr_assert_q <= 1'b0;
    end
    else
    begin
      ctl0_q       <= ctl0;
      ddr_ready_q  <= ddr_is_ready;
      flr_assert_q <= flr_assert;
    end
  end

  // FLR acknowledge, one pulse per rising request
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      flr_assert_qq <= 1'b0;
      flr_done      <= 1'b0;
    end
    else
    begin
      flr_assert_qq <= flr_assert_q;
      flr_done      <= flr_assert_q && !flr_assert_qq;
    end
  end

  // Control word fields
  assign scrb_en = ctl0_q[num_ch-1:0];
  assign dbg_en  = ctl0_q[ctl_dbg_en_bit];
  assign dbg_sel = ctl0_q[ctl_dbg_sel_lsb +: ctl_dbg_sel_w];

endmodule

`default_nettype wire

// ==== hw/rst_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module rst_sync (
  input  wire  clk,
  input  wire  rst_main_n,
  output logic sync_rst_n
);

  logic [3:0] rst_pipe;
  logic       pipe_rst_n;
  logic       pre_sync_rst_n;

  // Raw board reset through a plain shift register
  always_ff @(posedge clk)
  begin
    rst_pipe <= {rst_pipe[2:0], rst_main_n};
  end

  assign pipe_rst_n = rst_pipe[3];

  // Two-flop synchronizer, asserts as soon as the piped reset falls
  always_ff @(posedge clk or negedge pipe_rst_n)
  begin
    if (!pipe_rst_n)
    begin
      pre_sync_rst_n <= 1'b0;
      sync_rst_n     <= 1'b0;
    end
    else
    begin
      pre_sync_rst_n <= 1'b1;
      sync_rst_n     <= pre_sync_rst_n;
    end
  end

endmodule

`default_nettype wire

// ==== common/scrub_pkg.sv ====
`default_nettype none

package scrub_pkg;

  // --------------------------------------------------
  // Channel and bus sizing
  // --------------------------------------------------
  localparam int num_ch   = 4;
  localparam int ch_idx_w = $clog2(num_ch);
  localparam int addr_w   = 64;
  localparam int data_w   = 512;
  localparam int strb_w   = data_w / 8;
  localparam int id_w     = 16;

  // Scrub burst shape, 16 beats of 64 bytes
  localparam int                burst_beats   = 16;
  localparam logic [7:0]        burst_len     = 8'(burst_beats - 1);
  localparam logic [2:0]        burst_size    = 3'd6;
  localparam logic [addr_w-1:0] burst_bytes   = addr_w'(burst_beats * strb_w);
  localparam logic [addr_w-1:0] scrb_max_addr = 64'h1FFF;

  // Fixed identification words
  localparam logic [31:0] cl_id0 = 32'hF000_1D0F;
  localparam logic [31:0] cl_id1 = 32'h1D51_FEDC;

  // Control word fields, low bits are per-channel enables
  localparam int ctl_dbg_en_bit  = 31;
  localparam int ctl_dbg_sel_lsb = 28;
  localparam int ctl_dbg_sel_w   = 3;

  // Scrubber FSM encoding
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_addr = 2'd1;
  localparam logic [1:0] st_data = 2'd2;
  localparam logic [1:0] st_resp = 2'd3;

  // Scrub address, counted in full and reported in halves
  typedef union packed {
    logic [addr_w-1:0] full;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } scrb_addr_u;

endpackage

`default_nettype wire
